/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = rv_core_tb
FILELIST = rv_core.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
PASS_MSG = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN    = 32;
    localparam int PC_W    = 12;  // byte pc, 4 KiB of program space
    localparam int IADDR_W = 10;
    localparam int DADDR_W = 10;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSN = 32'h0000_0013;

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111
    } rv_opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui
    } alu_op_e;

    // write-back source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK
    } wb_sel_e;

endpackage

/* decode/rv_decode.sv */
`timescale 1ns/1ps

module rv_decode (
    input  logic [rv_pkg::XLEN-1:0] insn,
    output logic                    reg_write,
    output logic                    mem_read,
    output logic                    mem_write,
    output logic                    branch,
    output logic                    jump,
    output logic                    alu_src_imm,
    output logic                    a_sel_pc,
    output rv_pkg::wb_sel_e         wb_sel,
    output logic [rv_pkg::XLEN-1:0] imm
);
    import rv_pkg::*;

    rv_opcode_e opcode;

    assign opcode = rv_opcode_e'(insn[6:0]);

    always_comb begin
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        alu_src_imm = 1'b0;
        a_sel_pc    = 1'b0;
        wb_sel      = WB_ALU;
        case (opcode)
            OP_R: begin
                reg_write = 1'b1;
            end
            OP_IMM, OP_LUI: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_LOAD: begin
                reg_write   = 1'b1;
                mem_read    = 1'b1;
                alu_src_imm = 1'b1;
                wb_sel      = WB_MEM;
            end
            OP_STORE: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_BRANCH: begin
                branch = 1'b1;  // compare rs1 - rs2
            end
            OP_AUIPC: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                a_sel_pc    = 1'b1;
            end
            OP_JAL: begin
                reg_write = 1'b1;
                jump      = 1'b1;
                wb_sel    = WB_LINK;
            end
            default: ;  // unknown opcode stays a bubble
        endcase
    end

    // sign-extended immediate by format
    always_comb begin
        case (opcode)
            OP_IMM, OP_LOAD:
                imm = {{20{insn[31]}}, insn[31:20]};
            OP_STORE:
                imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
            OP_BRANCH:
                imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
            OP_LUI, OP_AUIPC:
                imm = {insn[31:12], 12'b0};
            OP_JAL:
                imm = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

/* decode/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
    input  logic                    CLK,
    input  logic                    RESET_N,
    input  logic [4:0]              rs1_addr,
    input  logic [4:0]              rs2_addr,
    input  logic [4:0]              rd_addr,
    input  logic [rv_pkg::XLEN-1:0] rd_data,
    input  logic                    rd_we,
    output logic [rv_pkg::XLEN-1:0] rs1_data,
    output logic [rv_pkg::XLEN-1:0] rs2_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // same-cycle write is seen by the reader
    function automatic logic [XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0)
            return '0;
        else if (rd_we && rd_addr == addr)
            return rd_data;
        else
            return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic                         CLK,
    input  logic                         RESET_N,
    input  logic [rv_pkg::XLEN-1:0]      idata,
    input  logic [rv_pkg::XLEN-1:0]      ddata_r,
    output logic [rv_pkg::IADDR_W-1:0]   iaddr,
    output logic [rv_pkg::DADDR_W-1:0]   daddr,
    output logic [rv_pkg::XLEN-1:0]      ddata_w,
    output logic                         mem_read,
    output logic                         mem_write
);
    import rv_pkg::*;

    logic [PC_W-1:0] pc;
    logic [PC_W-1:0] pc_plus4;
    logic            taken;

    logic            ifid_valid;
    logic [PC_W-1:0] ifid_pc;
    logic [XLEN-1:0] ifid_insn;

    logic            dec_reg_write, dec_mem_read, dec_mem_write;
    logic            dec_branch, dec_jump, dec_alu_src_imm, dec_a_sel_pc;
    wb_sel_e         dec_wb_sel;
    logic [XLEN-1:0] dec_imm;
    logic [XLEN-1:0] rs1_data, rs2_data;

    logic            idex_valid;
    logic [PC_W-1:0] idex_pc;
    rv_opcode_e      idex_opcode;
    logic [2:0]      idex_funct3;
    logic            idex_bit30;
    logic [4:0]      idex_rd;
    logic [XLEN-1:0] idex_rs1, idex_rs2, idex_imm;
    logic            idex_reg_write, idex_mem_read, idex_mem_write;
    logic            idex_branch, idex_jump, idex_alu_src_imm, idex_a_sel_pc;
    wb_sel_e         idex_wb_sel;

    logic [XLEN-1:0] alu_a, alu_b, alu_result;
    logic            alu_zero;
    logic [PC_W-1:0] ex_target, ex_link;

    logic            exmem_valid;
    logic [XLEN-1:0] exmem_alu, exmem_rs2;
    logic            exmem_zero, exmem_bne;
    logic [4:0]      exmem_rd;
    logic [PC_W-1:0] exmem_target, exmem_link;
    logic            exmem_reg_write, exmem_mem_read, exmem_mem_write;
    logic            exmem_branch, exmem_jump;
    wb_sel_e         exmem_wb_sel;

    logic            memwb_valid;
    logic [XLEN-1:0] memwb_alu, memwb_rdata;
    logic [PC_W-1:0] memwb_link;
    logic [4:0]      memwb_rd;
    logic            memwb_reg_write;
    wb_sel_e         memwb_wb_sel;
    logic [XLEN-1:0] wb_data;
    logic            wb_we;

    // pc and the valid chain, a taken transfer kills the three younger slots
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc          <= '0;
            ifid_valid  <= 1'b0;
            idex_valid  <= 1'b0;
            exmem_valid <= 1'b0;
            memwb_valid <= 1'b0;
        end else begin
            pc          <= taken ? exmem_target : pc_plus4;
            ifid_valid  <= ~taken;
            idex_valid  <= ifid_valid & ~taken;
            exmem_valid <= idex_valid & ~taken;
            memwb_valid <= exmem_valid;
        end
    end

    assign pc_plus4 = pc + PC_W'(4);
    assign iaddr    = pc[IADDR_W+1:2];

    always_ff @(posedge CLK) begin
        ifid_pc   <= pc;
        ifid_insn <= taken ? NOP_INSN : idata;
    end

    rv_decode u_decode (
        .insn        (ifid_insn),
        .reg_write   (dec_reg_write),
        .mem_read    (dec_mem_read),
        .mem_write   (dec_mem_write),
        .branch      (dec_branch),
        .jump        (dec_jump),
        .alu_src_imm (dec_alu_src_imm),
        .a_sel_pc    (dec_a_sel_pc),
        .wb_sel      (dec_wb_sel),
        .imm         (dec_imm)
    );

    rv_regfile u_regfile (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .rs1_addr (ifid_insn[19:15]),
        .rs2_addr (ifid_insn[24:20]),
        .rd_addr  (memwb_rd),
        .rd_data  (wb_data),
        .rd_we    (wb_we),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    always_ff @(posedge CLK) begin
        idex_pc          <= ifid_pc;
        idex_opcode      <= rv_opcode_e'(ifid_insn[6:0]);
        idex_funct3      <= ifid_insn[14:12];
        idex_bit30       <= ifid_insn[30];
        idex_rd          <= ifid_insn[11:7];
        idex_rs1         <= rs1_data;
        idex_rs2         <= rs2_data;
        idex_imm         <= dec_imm;
        idex_reg_write   <= dec_reg_write;
        idex_mem_read    <= dec_mem_read;
        idex_mem_write   <= dec_mem_write;
        idex_branch      <= dec_branch;
        idex_jump        <= dec_jump;
        idex_alu_src_imm <= dec_alu_src_imm;
        idex_a_sel_pc    <= dec_a_sel_pc;
        idex_wb_sel      <= dec_wb_sel;
    end

    assign alu_a     = idex_a_sel_pc ? {{(XLEN-PC_W){1'b0}}, idex_pc} : idex_rs1;  // auipc
    assign alu_b     = idex_alu_src_imm ? idex_imm : idex_rs2;
    assign ex_target = idex_pc + idex_imm[PC_W-1:0];
    assign ex_link   = idex_pc + PC_W'(4);  // own pc, not the fetch pc

    rv_alu u_alu (
        .opcode (idex_opcode),
        .funct3 (idex_funct3),
        .bit30  (idex_bit30),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    always_ff @(posedge CLK) begin
        exmem_alu       <= alu_result;
        exmem_zero      <= alu_zero;
        exmem_bne       <= idex_funct3[0];
        exmem_rs2       <= idex_rs2;
        exmem_rd        <= idex_rd;
        exmem_target    <= ex_target;
        exmem_link      <= ex_link;
        exmem_reg_write <= idex_reg_write;
        exmem_mem_read  <= idex_mem_read;
        exmem_mem_write <= idex_mem_write;
        exmem_branch    <= idex_branch;
        exmem_jump      <= idex_jump;
        exmem_wb_sel    <= idex_wb_sel;
    end

    // beq on zero, bne on not zero, jal always
    assign taken = exmem_valid &
                   (exmem_jump | (exmem_branch & (exmem_bne ^ exmem_zero)));

    assign daddr     = exmem_alu[DADDR_W+1:2];
    assign ddata_w   = exmem_rs2;
    assign mem_read  = exmem_valid & exmem_mem_read;
    assign mem_write = exmem_valid & exmem_mem_write;

    always_ff @(posedge CLK) begin
        memwb_alu       <= exmem_alu;
        memwb_rdata     <= ddata_r;
        memwb_link      <= exmem_link;
        memwb_rd        <= exmem_rd;
        memwb_reg_write <= exmem_reg_write;
        memwb_wb_sel    <= exmem_wb_sel;
    end

    always_comb begin
        case (memwb_wb_sel)
            WB_MEM:  wb_data = memwb_rdata;
            WB_LINK: wb_data = {{(XLEN-PC_W){1'b0}}, memwb_link};
            default: wb_data = memwb_alu;
        endcase
    end

    assign wb_we = memwb_valid & memwb_reg_write;

endmodule

/* execute/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::rv_opcode_e      opcode,
    input  logic [2:0]              funct3,
    input  logic                    bit30,
    input  logic [rv_pkg::XLEN-1:0] a,
    input  logic [rv_pkg::XLEN-1:0] b,
    output logic [rv_pkg::XLEN-1:0] result,
    output logic                    zero
);
    import rv_pkg::*;

    alu_op_e    op;
    logic [4:0] shamt;

    // alu control
    always_comb begin
        case (opcode)
            OP_R, OP_IMM: begin
                case (funct3)
                    3'b000:  op = (opcode == OP_R && bit30) ? ALU_SUB : ALU_ADD;
                    3'b001:  op = ALU_SLL;
                    3'b010:  op = ALU_SLT;
                    3'b011:  op = ALU_SLTU;
                    3'b100:  op = ALU_XOR;
                    3'b101:  op = bit30 ? ALU_SRA : ALU_SRL;  // srai keeps bit30 too
                    3'b110:  op = ALU_OR;
                    default: op = ALU_AND;
                endcase
            end
            OP_BRANCH: op = ALU_SUB;
            OP_LUI:    op = ALU_PASS_B;
            default:   op = ALU_ADD;  // address and auipc sums
        endcase
    end

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU:   result = {{(XLEN-1){1'b0}}, a < b};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* rv_core.f */
common/rv_pkg.sv
decode/rv_regfile.sv
decode/rv_decode.sv
execute/rv_alu.sv
design/rv_core.sv
sim/rv_core_assert.sv
sim/rv_core_check.sv
sim/rv_core_tb.sv

/* sim/rv_core_assert.sv */
`timescale 1ns/1ps

module rv_core_assert (
    input logic                       CLK,
    input logic                       RESET_N,
    input logic [rv_pkg::IADDR_W-1:0] iaddr,
    input logic                       mem_read,
    input logic                       mem_write
);

    a_rw_exclusive: assert property (@(posedge CLK) disable iff (!RESET_N)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write high in the same cycle");

    a_quiet_in_reset: assert property (@(posedge CLK)
        !RESET_N |-> (!mem_read && !mem_write))
        else $error("memory strobe active during reset");

    // first cycle out of reset
    a_quiet_after_reset: assert property (@(posedge CLK)
        $rose(RESET_N) |-> (!mem_read && !mem_write))
        else $error("memory strobe active right after reset");

    a_iaddr_start: assert property (@(posedge CLK)
        $rose(RESET_N) |-> (iaddr == '0))
        else $error("iaddr not zero in the first cycle after reset");

    a_write_known: assert property (@(posedge CLK) disable iff (!RESET_N)
        !$isunknown(mem_write))
        else $error("mem_write is unknown");

endmodule

/* sim/rv_core_check.sv */
`timescale 1ns/1ps

module rv_core_check (
    input  logic                       CLK,
    input  logic                       RESET_N,
    input  logic [rv_pkg::DADDR_W-1:0] daddr,
    input  logic [rv_pkg::XLEN-1:0]    ddata_w,
    input  logic                       mem_write,
    output logic                       done,
    output int                         errors
);
    import rv_pkg::*;

    logic [8*16-1:0]    exp_name [$];
    logic [DADDR_W-1:0] exp_addr [$];
    logic [XLEN-1:0]    exp_data [$];

    int   seen     = 0;
    int   passed   = 0;
    int   fails    = 0;
    logic all_seen = 1'b0;

    assign done   = all_seen;
    assign errors = fails;

    task automatic add_expect(input logic [8*16-1:0] name, input logic [DADDR_W-1:0] addr,
                              input logic [XLEN-1:0] data);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic compare_store();
        bit ok;
        ok = 1'b1;
        if (seen >= exp_addr.size()) begin
            $display("unexpected store of 0x%h to word address 0x%h after the expected list",
                     ddata_w, daddr);
            fails++;
            return;
        end
        if (daddr !== exp_addr[seen]) begin
            $display("[ERROR] %0s daddr expected 0x%h actual 0x%h",
                     exp_name[seen], exp_addr[seen], daddr);
            ok = 1'b0;
        end
        if (ddata_w !== exp_data[seen]) begin
            $display("[ERROR] %0s ddata_w expected 0x%h actual 0x%h",
                     exp_name[seen], exp_data[seen], ddata_w);
            ok = 1'b0;
        end
        if (ok) begin
            $display("%0s pass", exp_name[seen]);
            passed++;
        end else begin
            fails++;
        end
        seen++;
    endtask

    // one record per store strobe, in program order
    always @(posedge CLK) begin
        if (RESET_N && mem_write)
            compare_store();
        all_seen <= (seen >= exp_addr.size());
    end

    task automatic report_counts();
        $display("stores: %0d expected, %0d seen, %0d passed, %0d failed",
                 exp_addr.size(), seen, passed, fails);
    endtask

endmodule

/* sim/rv_core_input.txt */
# P <rom word address> <instruction>, D <ram word address> <data>
# E <test name> <daddr> <ddata_w>, expected stores in program order, all values hex
# operands x1 = -6, x2 = 3
P 00 FFA00093
P 01 00300113
# r-type into x3..x12, i-type into x13..x21
P 04 002081B3
P 05 40208233
P 06 002092B3
P 07 0020A333
P 08 0020B3B3
P 09 0020C433
P 0A 0020D4B3
P 0B 4020D533
P 0C 0020E5B3
P 0D 0020F633
P 0E 12308693
P 0F 0050A713
P 10 0050B793
P 11 0F00C813
P 12 0010E893
P 13 7F00F913
P 14 00409993
P 15 0040DA13
P 16 4040DA93
# stores of x3..x21 to byte 0x100 upward
P 17 10302023
P 18 10402223
P 19 10502423
P 1A 10602623
P 1B 10702823
P 1C 10802A23
P 1D 10902C23
P 1E 10A02E23
P 1F 12B02023
P 20 12C02223
P 21 12D02423
P 22 12E02623
P 23 12F02823
P 24 13002A23
P 25 13102C23
P 26 13202E23
P 27 15302023
P 28 15402223
P 29 15502423
# lui, auipc, lw then add
P 2A 12345B37
P 2B 00001B97
P 2C 20002C03
P 2D 15602623
P 2E 15702823
P 2F 002C0CB3
P 32 15902A23
# branches, shadow stores go to byte 0x180 and up
P 33 00108863
P 34 18202023
P 37 14102C23
P 38 00208863
P 39 14202E23
P 3C 00209863
P 3D 18202223
P 40 16102023
P 41 00211863
P 42 16202223
# jal x26 forward, then jal to itself
P 43 01400D6F
P 44 18202423
P 48 17A02423
P 49 0000006F
D 80 13572468
E add 40 FFFFFFFD
E sub 41 FFFFFFF7
E sll 42 FFFFFFD0
E slt 43 00000001
E sltu 44 00000000
E xor 45 FFFFFFF9
E srl 46 1FFFFFFF
E sra 47 FFFFFFFF
E or 48 FFFFFFFB
E and 49 00000002
E addi 4A 0000011D
E slti 4B 00000001
E sltiu 4C 00000000
E xori 4D FFFFFF0A
E ori 4E FFFFFFFB
E andi 4F 000007F0
E slli 50 FFFFFFA0
E srli 51 0FFFFFFF
E srai 52 FFFFFFFF
E lui 53 12345000
E auipc 54 000010AC
E lw_add 55 1357246B
E beq_taken 56 FFFFFFFA
E beq_not_taken 57 00000003
E bne_taken 58 FFFFFFFA
E bne_not_taken 59 00000003
E jal_link 5A 00000110

/* sim/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;
    import rv_pkg::*;

    localparam int MAX_CYCLES  = 1000;
    localparam int IDLE_CYCLES = 20;
    localparam int MEM_WORDS   = 1024;

    logic                CLK;
    logic                RESET_N;
    logic [XLEN-1:0]     idata;
    logic [XLEN-1:0]     ddata_r;
    logic [IADDR_W-1:0]  iaddr;
    logic [DADDR_W-1:0]  daddr;
    logic [XLEN-1:0]     ddata_w;
    logic                mem_read;
    logic                mem_write;
    logic                done;
    int                  errors;
    bit                  load_failed = 1'b0;

    logic [XLEN-1:0] rom [0:MEM_WORDS-1];
    logic [XLEN-1:0] ram [0:MEM_WORDS-1];

    rv_core rv_core_i (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .idata     (idata),
        .ddata_r   (ddata_r),
        .iaddr     (iaddr),
        .daddr     (daddr),
        .ddata_w   (ddata_w),
        .mem_read  (mem_read),
        .mem_write (mem_write)
    );

    rv_core_check check_i (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .daddr     (daddr),
        .ddata_w   (ddata_w),
        .mem_write (mem_write),
        .done      (done),
        .errors    (errors)
    );

    bind rv_core rv_core_assert u_assert (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .iaddr     (iaddr),
        .mem_read  (mem_read),
        .mem_write (mem_write)
    );

    // both memories answer in the same cycle
    assign idata   = rom[iaddr];
    assign ddata_r = mem_read ? ram[daddr] : '0;  // ram drives data only on a read

    always @(posedge CLK) begin
        if (mem_write)
            ram[daddr] <= ddata_w;
    end

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // reads P, D and E records and skips # comment lines
    task automatic load_input();
        int              fd;
        int              n;
        logic [7:0]      tag;
        logic [31:0]     addr;
        logic [31:0]     word;
        logic [8*16-1:0] name;
        logic [8*256-1:0] line;
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[IADDR_W'(i)] = NOP_INSN;
            ram[DADDR_W'(i)] <= '0;
        end
        fd = $fopen("sim/rv_core_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the input file sim/rv_core_input.txt");
            load_failed = 1'b1;
            return;
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            n = 3;
            case (tag)
                "P": n = $fscanf(fd, "%h %h", addr, word) + 1;
                "D": n = $fscanf(fd, "%h %h", addr, word) + 1;
                "E": n = $fscanf(fd, "%s %h %h", name, addr, word);
                "#": n = $fgets(line, fd) > 0 ? 3 : 0;
                default: n = 0;
            endcase
            if (n != 3) begin
                $display("input file has a bad record starting with '%c'", tag);
                load_failed = 1'b1;
            end else if (tag == "P") begin
                rom[addr[IADDR_W-1:0]] = word;
            end else if (tag == "D") begin
                ram[addr[DADDR_W-1:0]] <= word;
            end else if (tag == "E") begin
                check_i.add_expect(name, addr[DADDR_W-1:0], word);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int cycles;
        bit timed_out;
        RESET_N = 1'b0;
        load_input();
        repeat (10) @(posedge CLK);
        #5 RESET_N = 1'b1;

        cycles = 0;
        while (!done && cycles < MAX_CYCLES) begin
            @(posedge CLK);
            cycles++;
        end
        timed_out = !done;
        if (timed_out)
            $display("program never finished, expected stores still missing after %0d cycles",
                     cycles);
        else
            repeat (IDLE_CYCLES) @(posedge CLK);  // catch stray stores after the last one

        check_i.report_counts();
        if (timed_out || load_failed || errors != 0) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule
